/* source/decoder_pkg.sv */
package decoder_pkg;

    // shared with the processing elements, so the encoding matters
    typedef enum logic [2:0] {
        STAGE_IDLE                  = 3'd0,
        STAGE_MEASUREMENT_LOADING   = 3'd1,
        STAGE_GROW                  = 3'd2,
        STAGE_MERGE                 = 3'd3,
        STAGE_PEELING               = 3'd4,
        STAGE_RESULT_VALID          = 3'd5,
        STAGE_PARAMETERS_LOADING    = 3'd6,
        STAGE_MEASUREMENT_PREPARING = 3'd7
    } stage_t;

    typedef enum logic [7:0] {
        OP_START_DECODING   = 8'h01,
        OP_MEASUREMENT_DATA = 8'h02,
        OP_MOVE_TO_STAGE    = 8'h03
    } ctrl_opcode_t;

    typedef struct packed {
        logic [15:0] reserved;
        logic [7:0]  header;   // opcode, or iterations on the way out
        logic [15:0] count;
        logic [23:0] payload;
    } ctrl_msg_t;

    typedef struct packed {
        logic [7:0]  iterations;
        logic [15:0] cycles;
    } decode_stats_t;

    // iteration byte plus two cycle bytes
    localparam int HEADER_BYTES = 3;

endpackage

/* source/stage_controller.sv */
`timescale 1ns/100ps

module stage_controller #(
    parameter GRID_WIDTH_X = 4,
    parameter GRID_WIDTH_Z = 1,
    parameter GRID_WIDTH_U = 3,
    parameter MAXIMUM_DELAY = 3
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  decoder_pkg::ctrl_msg_t                       ctrl_rx,
    input  logic                                         ctrl_rx_valid,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] busy_pe,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] odd_clusters_pe,
    input  logic                                         round_done,
    output decoder_pkg::stage_t                          global_stage,
    output logic                                         ctrl_rx_ready,
    output logic                                         decode_start,
    output logic                                         reset_all_edges
);

    localparam DELAY_WIDTH = $clog2(MAXIMUM_DELAY + 2);
    localparam ROUND_WIDTH = $clog2(GRID_WIDTH_U + 1);

    logic [DELAY_WIDTH-1:0] delay_counter;
    logic [ROUND_WIDTH-1:0] round_counter;   // rounds loaded, later rounds output
    logic busy;
    logic odd_clusters;
    logic accept;
    decoder_pkg::ctrl_opcode_t opcode;

    // one cycle old summaries of the PE array
    always_ff @(posedge clk) begin
        busy <= |busy_pe;
        odd_clusters <= |odd_clusters_pe;
    end

    assign ctrl_rx_ready = (global_stage == decoder_pkg::STAGE_IDLE);
    assign accept = ctrl_rx_valid && ctrl_rx_ready;
    assign opcode = decoder_pkg::ctrl_opcode_t'(ctrl_rx.header);
    assign decode_start = accept && (opcode == decoder_pkg::OP_MEASUREMENT_DATA);
    assign reset_all_edges = (global_stage == decoder_pkg::STAGE_MEASUREMENT_LOADING);

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage <= decoder_pkg::STAGE_IDLE;
            delay_counter <= '0;
            round_counter <= '0;
        end else begin
            case (global_stage)
                decoder_pkg::STAGE_IDLE: begin
                    if (accept) begin
                        case (opcode)
                            decoder_pkg::OP_START_DECODING: begin
                                global_stage <= decoder_pkg::STAGE_PARAMETERS_LOADING;
                            end
                            decoder_pkg::OP_MEASUREMENT_DATA: begin
                                global_stage <= decoder_pkg::STAGE_MEASUREMENT_PREPARING;
                                round_counter <= '0;
                            end
                            decoder_pkg::OP_MOVE_TO_STAGE: begin
                                global_stage <= decoder_pkg::STAGE_GROW;
                            end
                            default: ;   // unknown opcode, drop it
                        endcase
                    end
                end
                decoder_pkg::STAGE_PARAMETERS_LOADING: begin
                    global_stage <= decoder_pkg::STAGE_IDLE;
                end
                decoder_pkg::STAGE_MEASUREMENT_PREPARING: begin
                    if (round_done) begin
                        global_stage <= decoder_pkg::STAGE_MEASUREMENT_LOADING;
                        round_counter <= round_counter + 1'b1;
                    end
                end
                decoder_pkg::STAGE_MEASUREMENT_LOADING: begin
                    if (round_counter < GRID_WIDTH_U) begin
                        global_stage <= decoder_pkg::STAGE_MEASUREMENT_PREPARING;
                    end else begin
                        global_stage <= decoder_pkg::STAGE_GROW;
                    end
                end
                decoder_pkg::STAGE_GROW: begin
                    global_stage <= decoder_pkg::STAGE_MERGE;
                    delay_counter <= '0;
                end
                decoder_pkg::STAGE_MERGE: begin
                    // settle first, then wait for the array to go quiet
                    if (delay_counter >= MAXIMUM_DELAY) begin
                        if (!busy) begin
                            global_stage <= odd_clusters ? decoder_pkg::STAGE_GROW
                                                         : decoder_pkg::STAGE_PEELING;
                        end
                    end else begin
                        delay_counter <= delay_counter + 1'b1;
                    end
                end
                decoder_pkg::STAGE_PEELING: begin
                    global_stage <= decoder_pkg::STAGE_RESULT_VALID;
                    round_counter <= '0;
                end
                decoder_pkg::STAGE_RESULT_VALID: begin
                    round_counter <= round_counter + 1'b1;
                    if (round_counter == GRID_WIDTH_U - 1) begin
                        global_stage <= decoder_pkg::STAGE_IDLE;
                    end
                end
                default: global_stage <= decoder_pkg::STAGE_IDLE;
            endcase
        end
    end

endmodule

/* source/measurement_loader.sv */
`timescale 1ns/100ps

module measurement_loader #(
    parameter GRID_WIDTH_X = 4,
    parameter GRID_WIDTH_Z = 1
) (
    input  logic                clk,
    input  logic                reset,
    input  decoder_pkg::stage_t global_stage,
    input  logic [7:0]          input_data,
    input  logic                input_valid,
    output logic                input_ready,
    output logic [((GRID_WIDTH_X*GRID_WIDTH_Z+7)/8)*8-1:0] measurements,
    output logic                round_done
);

    localparam PU_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam BYTES_PER_ROUND = (PU_PER_ROUND + 7) / 8;
    localparam ALIGNED_PU_PER_ROUND = BYTES_PER_ROUND * 8;
    localparam COUNT_WIDTH = $clog2(BYTES_PER_ROUND + 1);

    logic [COUNT_WIDTH-1:0] byte_count;
    logic [ALIGNED_PU_PER_ROUND+7:0] shifted;
    logic accept;

    assign input_ready = (global_stage == decoder_pkg::STAGE_MEASUREMENT_PREPARING);
    assign accept = input_valid && input_ready;
    assign round_done = accept && (byte_count == BYTES_PER_ROUND - 1);
    assign shifted = {input_data, measurements};   // new byte enters from the top

    always_ff @(posedge clk) begin
        if (accept) begin
            measurements <= shifted[ALIGNED_PU_PER_ROUND+7:8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_count <= '0;
        end else if (accept) begin
            if (round_done) begin
                byte_count <= '0;
            end else begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

endmodule

/* source/decode_statistics.sv */
`timescale 1ns/100ps

module decode_statistics (
    input  logic                       clk,
    input  logic                       reset,
    input  decoder_pkg::stage_t        global_stage,
    input  logic                       decode_start,
    output decoder_pkg::decode_stats_t stats,
    output decoder_pkg::ctrl_msg_t     ctrl_tx,
    output logic                       ctrl_tx_valid
);

    logic [7:0] iteration_counter;
    logic [15:0] cycle_counter;
    logic result_sent;
    logic counting;

    assign counting = (global_stage == decoder_pkg::STAGE_GROW)
                   || (global_stage == decoder_pkg::STAGE_MERGE)
                   || (global_stage == decoder_pkg::STAGE_PEELING);

    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
            cycle_counter <= '0;
        end else begin
            if (global_stage == decoder_pkg::STAGE_MEASUREMENT_LOADING) begin
                iteration_counter <= '0;
            end else if (global_stage == decoder_pkg::STAGE_GROW) begin
                iteration_counter <= iteration_counter + 1'b1;   // grow is single cycle
            end
            if (decode_start) begin
                cycle_counter <= 16'd1;   // counts the current cycle, not elapsed ones
            end else if (counting) begin
                cycle_counter <= cycle_counter + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_sent <= 1'b0;
        end else if (global_stage == decoder_pkg::STAGE_RESULT_VALID) begin
            result_sent <= 1'b1;
        end else if (global_stage == decoder_pkg::STAGE_IDLE) begin
            result_sent <= 1'b0;
        end
    end

    assign stats = {iteration_counter, cycle_counter};
    assign ctrl_tx_valid = (global_stage == decoder_pkg::STAGE_RESULT_VALID) && !result_sent;

    always_comb begin
        ctrl_tx = '0;
        ctrl_tx.header = iteration_counter;
        ctrl_tx.count = cycle_counter;
    end

endmodule

/* source/correction_buffer.sv */
`timescale 1ns/100ps

module correction_buffer #(
    parameter GRID_WIDTH_X = 4,
    parameter GRID_WIDTH_Z = 1,
    parameter FIFO_DEPTH = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  decoder_pkg::stage_t global_stage,
    input  logic [2*(GRID_WIDTH_X-1)*GRID_WIDTH_Z+1+GRID_WIDTH_X*GRID_WIDTH_Z-1:0] correction,
    input  logic                word_ready,
    output logic [2*(GRID_WIDTH_X-1)*GRID_WIDTH_Z+1+GRID_WIDTH_X*GRID_WIDTH_Z-1:0] word,
    output logic                word_valid
);

    localparam CORRECTION_WIDTH = 2 * (GRID_WIDTH_X - 1) * GRID_WIDTH_Z + 1
                                + GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [CORRECTION_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [COUNT_WIDTH-1:0] fill;
    decoder_pkg::stage_t stage_d;
    logic push;
    logic pop;

    always_ff @(posedge clk) begin
        if (reset) stage_d <= decoder_pkg::STAGE_IDLE;
        else stage_d <= global_stage;
    end

    // PEs present a round's correction one cycle into result valid
    assign push = (stage_d == decoder_pkg::STAGE_RESULT_VALID) && (fill != FIFO_DEPTH);
    assign pop = word_valid && word_ready;
    assign word_valid = (fill != 0);
    assign word = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= correction;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) fill <= fill + 1'b1;
            else if (pop && !push) fill <= fill - 1'b1;
        end
    end

endmodule

/* source/result_serializer.sv */
`timescale 1ns/100ps

module result_serializer #(
    parameter GRID_WIDTH_X = 4,
    parameter GRID_WIDTH_Z = 1,
    parameter GRID_WIDTH_U = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  decoder_pkg::decode_stats_t stats,
    input  logic [2*(GRID_WIDTH_X-1)*GRID_WIDTH_Z+1+GRID_WIDTH_X*GRID_WIDTH_Z-1:0] word,
    input  logic                       word_valid,
    input  logic                       output_ready,
    output logic                       word_ready,
    output logic [7:0]                 output_data,
    output logic                       output_valid
);

    localparam CORRECTION_WIDTH = 2 * (GRID_WIDTH_X - 1) * GRID_WIDTH_Z + 1
                                + GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam WORD_BYTES = (CORRECTION_WIDTH + 7) / 8;
    localparam FRAME_BYTES = decoder_pkg::HEADER_BYTES + GRID_WIDTH_U * WORD_BYTES;
    localparam FRAME_WIDTH = $clog2(FRAME_BYTES + 1);
    localparam SEL_WIDTH = $clog2(WORD_BYTES + 1);

    logic [FRAME_WIDTH-1:0] frame_count;
    logic [SEL_WIDTH-1:0] byte_sel;   // byte within the current word
    logic [WORD_BYTES*8-1:0] padded;
    logic in_header;
    logic transfer;

    assign padded = {{(WORD_BYTES*8-CORRECTION_WIDTH){1'b0}}, word};
    assign in_header = (frame_count < decoder_pkg::HEADER_BYTES);

    // frame held back until a word is ready, header included
    assign output_valid = word_valid;
    assign transfer = output_valid && output_ready;
    assign word_ready = output_ready && !in_header && (byte_sel == WORD_BYTES - 1);

    always_comb begin
        case (frame_count)
            0: output_data = stats.iterations;
            1: output_data = stats.cycles[15:8];
            2: output_data = stats.cycles[7:0];
            default: output_data = padded[byte_sel*8 +: 8];   // lsb first
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count <= '0;
            byte_sel <= '0;
        end else if (transfer) begin
            if (frame_count == FRAME_BYTES - 1) frame_count <= '0;
            else frame_count <= frame_count + 1'b1;
            if (!in_header) begin
                if (byte_sel == WORD_BYTES - 1) byte_sel <= '0;
                else byte_sel <= byte_sel + 1'b1;
            end
        end
    end

endmodule

/* source/decoder_controller.sv */
`timescale 1ns/100ps

module decoder_controller #(
    parameter GRID_WIDTH_X = 4,
    parameter GRID_WIDTH_Z = 1,
    parameter GRID_WIDTH_U = 3,
    parameter MAXIMUM_DELAY = 3,
    parameter FIFO_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             input_data,
    input  logic                   input_valid,
    output logic                   input_ready,
    output logic [7:0]             output_data,
    output logic                   output_valid,
    input  logic                   output_ready,
    input  decoder_pkg::ctrl_msg_t ctrl_rx,
    input  logic                   ctrl_rx_valid,
    output logic                   ctrl_rx_ready,
    output decoder_pkg::ctrl_msg_t ctrl_tx,
    output logic                   ctrl_tx_valid,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] busy_pe,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] odd_clusters_pe,
    output logic [((GRID_WIDTH_X*GRID_WIDTH_Z+7)/8)*8-1:0] measurements,
    input  logic [2*(GRID_WIDTH_X-1)*GRID_WIDTH_Z+1+GRID_WIDTH_X*GRID_WIDTH_Z-1:0] correction,
    output decoder_pkg::stage_t    global_stage,
    output logic                   reset_all_edges
);

    localparam CORRECTION_WIDTH = 2 * (GRID_WIDTH_X - 1) * GRID_WIDTH_Z + 1
                                + GRID_WIDTH_X * GRID_WIDTH_Z;

    logic decode_start;
    logic round_done;
    decoder_pkg::decode_stats_t stats;
    logic [CORRECTION_WIDTH-1:0] word;
    logic word_valid;
    logic word_ready;

    stage_controller #(
        .GRID_WIDTH_X(GRID_WIDTH_X), .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U), .MAXIMUM_DELAY(MAXIMUM_DELAY)
    ) stage_ctrl (
        .clk(clk), .reset(reset),
        .ctrl_rx(ctrl_rx), .ctrl_rx_valid(ctrl_rx_valid),
        .busy_pe(busy_pe), .odd_clusters_pe(odd_clusters_pe),
        .round_done(round_done), .global_stage(global_stage),
        .ctrl_rx_ready(ctrl_rx_ready), .decode_start(decode_start),
        .reset_all_edges(reset_all_edges)
    );

    measurement_loader #(
        .GRID_WIDTH_X(GRID_WIDTH_X), .GRID_WIDTH_Z(GRID_WIDTH_Z)
    ) loader (
        .clk(clk), .reset(reset), .global_stage(global_stage),
        .input_data(input_data), .input_valid(input_valid), .input_ready(input_ready),
        .measurements(measurements), .round_done(round_done)
    );

    decode_statistics statistics (
        .clk(clk), .reset(reset), .global_stage(global_stage),
        .decode_start(decode_start), .stats(stats),
        .ctrl_tx(ctrl_tx), .ctrl_tx_valid(ctrl_tx_valid)
    );

    correction_buffer #(
        .GRID_WIDTH_X(GRID_WIDTH_X), .GRID_WIDTH_Z(GRID_WIDTH_Z), .FIFO_DEPTH(FIFO_DEPTH)
    ) output_fifo (
        .clk(clk), .reset(reset), .global_stage(global_stage),
        .correction(correction), .word_ready(word_ready),
        .word(word), .word_valid(word_valid)
    );

    result_serializer #(
        .GRID_WIDTH_X(GRID_WIDTH_X), .GRID_WIDTH_Z(GRID_WIDTH_Z),
        .GRID_WIDTH_U(GRID_WIDTH_U)
    ) serializer (
        .clk(clk), .reset(reset), .stats(stats),
        .word(word), .word_valid(word_valid), .output_ready(output_ready),
        .word_ready(word_ready), .output_data(output_data), .output_valid(output_valid)
    );

endmodule

/* bench/decoder_controller_sva.sv */
`timescale 1ns/100ps

module decoder_controller_sva (
    input logic                clk,
    input logic                reset,
    input decoder_pkg::stage_t global_stage,
    input logic                input_ready,
    input logic                output_valid,
    input logic                output_ready,
    input logic [7:0]          output_data,
    input logic                ctrl_tx_valid
);

    int assertion_failures = 0;   // read by the testbench at the end

    input_ready_in_preparing: assert property (@(posedge clk) disable iff (reset)
        input_ready |-> global_stage == decoder_pkg::STAGE_MEASUREMENT_PREPARING)
    else begin
        assertion_failures++;
        $error("input_ready high outside measurement preparing");
    end

    // stalled byte must hold
    output_held_while_stalled: assert property (@(posedge clk) disable iff (reset)
        output_valid && !output_ready |=> output_valid && $stable(output_data))
    else begin
        assertion_failures++;
        $error("output byte changed or dropped while output_ready was low");
    end

    result_message_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ctrl_tx_valid |=> !ctrl_tx_valid)
    else begin
        assertion_failures++;
        $error("ctrl_tx_valid high for two cycles in a row");
    end

    idle_after_reset: assert property (@(posedge clk)
        reset |=> global_stage == decoder_pkg::STAGE_IDLE)
    else begin
        assertion_failures++;
        $error("global_stage not idle in the cycle after reset");
    end

endmodule

bind decoder_controller decoder_controller_sva handshake_checks (
    .clk(clk), .reset(reset), .global_stage(global_stage),
    .input_ready(input_ready), .output_valid(output_valid),
    .output_ready(output_ready), .output_data(output_data),
    .ctrl_tx_valid(ctrl_tx_valid)
);

/* bench/decoder_controller_tb.sv */
`timescale 1ns/100ps

module decoder_controller_tb;

    localparam GRID_U = 3;
    localparam MAXIMUM_DELAY = 3;
    localparam PE_WIDTH = 4 * 1 * GRID_U;
    localparam MEAS_WIDTH = 8;
    localparam CORR_WIDTH = 2 * (4 - 1) * 1 + 1 + 4 * 1;
    localparam STAGE_TIMEOUT = 300;   // cycles
    localparam BUSY_HOLD = 6;
    localparam TEST_COUNT = 6;
    localparam TEST_TIME_NS = 4000;

    logic clk = 1'b0;
    logic reset;
    logic [7:0] input_data;
    logic input_valid;
    logic input_ready;
    logic [7:0] output_data;
    logic output_valid;
    logic output_ready;
    decoder_pkg::ctrl_msg_t ctrl_rx;
    logic ctrl_rx_valid;
    logic ctrl_rx_ready;
    decoder_pkg::ctrl_msg_t ctrl_tx;
    logic ctrl_tx_valid;
    logic [PE_WIDTH-1:0] busy_pe;
    logic [PE_WIDTH-1:0] odd_clusters_pe;
    logic [MEAS_WIDTH-1:0] measurements;
    logic [CORR_WIDTH-1:0] correction;
    decoder_pkg::stage_t global_stage;
    logic reset_all_edges;

    int errors = 0;
    int active_cycles;
    int grow_entries;
    int merge_run;
    int merge_lengths[$];
    decoder_pkg::stage_t prev_stage;

    decoder_controller uut (
        .clk(clk), .reset(reset),
        .input_data(input_data), .input_valid(input_valid), .input_ready(input_ready),
        .output_data(output_data), .output_valid(output_valid), .output_ready(output_ready),
        .ctrl_rx(ctrl_rx), .ctrl_rx_valid(ctrl_rx_valid), .ctrl_rx_ready(ctrl_rx_ready),
        .ctrl_tx(ctrl_tx), .ctrl_tx_valid(ctrl_tx_valid),
        .busy_pe(busy_pe), .odd_clusters_pe(odd_clusters_pe),
        .measurements(measurements), .correction(correction),
        .global_stage(global_stage), .reset_all_edges(reset_all_edges)
    );

    always #10 clk = ~clk;

    // statistics reference model sampled mid cycle
    always @(negedge clk) begin
        if (global_stage == decoder_pkg::STAGE_GROW && prev_stage != decoder_pkg::STAGE_GROW)
            grow_entries++;
        if (global_stage inside {decoder_pkg::STAGE_GROW, decoder_pkg::STAGE_MERGE,
                                 decoder_pkg::STAGE_PEELING})
            active_cycles++;
        if (global_stage == decoder_pkg::STAGE_MERGE) begin
            merge_run++;
        end else if (prev_stage == decoder_pkg::STAGE_MERGE) begin
            merge_lengths.push_back(merge_run);
            merge_run = 0;
        end
        prev_stage = global_stage;
    end

    initial begin
        #(TEST_COUNT * TEST_TIME_NS);
        $display("watchdog expired after %0d ns, tests did not finish", TEST_COUNT * TEST_TIME_NS);
        $display("Result: FAILED");
        $finish;
    end

    task automatic report_mismatch(input string test, input string what,
                                   input int expected, input int actual);
        errors++;
        $display("Fail %s: %s expected %0h actual %0h", test, what, expected, actual);
    endtask

    task automatic report_problem(input string text);
        errors++;
        $display("Error: %s", text);
    endtask

    // only called while idle, so the monitor is not counting
    task automatic clear_monitor;
        active_cycles = 0;
        grow_entries = 0;
        merge_run = 0;
        merge_lengths.delete();
    endtask

    task automatic wait_for_stage(input decoder_pkg::stage_t target, input string test);
        int guard;
        guard = 0;
        while (global_stage !== target && guard < STAGE_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (global_stage !== target)
            report_problem($sformatf("%s: stage %s was never reached", test, target.name()));
    endtask

    task automatic send_ctrl(input logic [7:0] opcode);
        int guard;
        guard = 0;
        ctrl_rx = '0;
        ctrl_rx.header = opcode;
        ctrl_rx_valid = 1'b1;
        while (!ctrl_rx_ready && guard < STAGE_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (!ctrl_rx_ready) report_problem("control message was never accepted");
        @(negedge clk);   // taken on the edge just passed
        ctrl_rx_valid = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] value);
        int guard;
        guard = 0;
        input_data = value;
        input_valid = 1'b1;
        while (!input_ready && guard < STAGE_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (!input_ready) report_problem("measurement byte was never accepted");
        @(negedge clk);
        input_valid = 1'b0;
    endtask

    task automatic start_decode;
        int r;
        clear_monitor();
        send_ctrl(decoder_pkg::OP_MEASUREMENT_DATA);
        for (r = 0; r < GRID_U; r++) send_byte($urandom);
    endtask

    task automatic test_reset;
        if (global_stage !== decoder_pkg::STAGE_IDLE)
            report_mismatch("reset", "global_stage", decoder_pkg::STAGE_IDLE, global_stage);
        if (ctrl_rx_ready !== 1'b1) report_mismatch("reset", "ctrl_rx_ready", 1, ctrl_rx_ready);
        if (input_ready !== 1'b0) report_mismatch("reset", "input_ready", 0, input_ready);
        if (output_valid !== 1'b0) report_mismatch("reset", "output_valid", 0, output_valid);
        if (ctrl_tx_valid !== 1'b0) report_mismatch("reset", "ctrl_tx_valid", 0, ctrl_tx_valid);
        if (reset_all_edges !== 1'b0)
            report_mismatch("reset", "reset_all_edges", 0, reset_all_edges);
    endtask

    task automatic test_start_message;
        send_ctrl(decoder_pkg::OP_START_DECODING);
        if (global_stage !== decoder_pkg::STAGE_PARAMETERS_LOADING)
            report_mismatch("start", "stage", decoder_pkg::STAGE_PARAMETERS_LOADING, global_stage);
        @(negedge clk);
        if (global_stage !== decoder_pkg::STAGE_IDLE)
            report_mismatch("start", "stage after one cycle", decoder_pkg::STAGE_IDLE, global_stage);
        send_ctrl(8'h7e);   // not a known opcode
        if (global_stage !== decoder_pkg::STAGE_IDLE)
            report_mismatch("unknown opcode", "stage", decoder_pkg::STAGE_IDLE, global_stage);
    endtask

    task automatic test_measurement_loading;
        int r;
        logic [7:0] value;
        clear_monitor();
        send_ctrl(decoder_pkg::OP_MEASUREMENT_DATA);
        if (global_stage !== decoder_pkg::STAGE_MEASUREMENT_PREPARING)
            report_mismatch("loading", "stage", decoder_pkg::STAGE_MEASUREMENT_PREPARING,
                            global_stage);
        for (r = 0; r < GRID_U; r++) begin
            value = $urandom;
            send_byte(value);
            if (global_stage !== decoder_pkg::STAGE_MEASUREMENT_LOADING)
                report_mismatch("loading", "stage", decoder_pkg::STAGE_MEASUREMENT_LOADING,
                                global_stage);
            if (reset_all_edges !== 1'b1)
                report_mismatch("loading", "reset_all_edges", 1, reset_all_edges);
            if (measurements[MEAS_WIDTH-1 -: 8] !== value)
                report_mismatch("loading", $sformatf("round %0d byte", r), value,
                                measurements[MEAS_WIDTH-1 -: 8]);
        end
        @(negedge clk);
        if (global_stage !== decoder_pkg::STAGE_GROW)
            report_mismatch("loading", "stage after last round", decoder_pkg::STAGE_GROW,
                            global_stage);
        wait_for_stage(decoder_pkg::STAGE_IDLE, "loading");
    endtask

    task automatic check_result(input string test, input int iterations);
        if (ctrl_tx_valid !== 1'b1) report_problem($sformatf("%s: no result message", test));
        if (grow_entries != iterations)
            report_mismatch(test, "grow entries", iterations, grow_entries);
        if (ctrl_tx.header !== iterations)
            report_mismatch(test, "iterations", iterations, ctrl_tx.header);
        if (ctrl_tx.count !== 16'(active_cycles + 1))
            report_mismatch(test, "cycles", active_cycles + 1, ctrl_tx.count);
        if (ctrl_tx.reserved !== '0 || ctrl_tx.payload !== '0)
            report_problem($sformatf("%s: reserved or payload field not zero", test));
    endtask

    task automatic test_single_iteration;
        busy_pe = '0;
        odd_clusters_pe = '0;
        start_decode();
        wait_for_stage(decoder_pkg::STAGE_RESULT_VALID, "single iteration");
        check_result("single iteration", 1);
        if (merge_lengths.size() != 1)
            report_mismatch("single iteration", "merge count", 1, merge_lengths.size());
        else if (merge_lengths[0] != MAXIMUM_DELAY + 1)
            report_mismatch("single iteration", "merge length", MAXIMUM_DELAY + 1,
                            merge_lengths[0]);
        wait_for_stage(decoder_pkg::STAGE_IDLE, "single iteration");
    endtask

    task automatic test_repeated_growth;
        int grows;
        int busy_left;
        int guard;
        int first_merge;
        grows = 0;
        busy_left = 0;
        guard = 0;
        start_decode();
        while (global_stage !== decoder_pkg::STAGE_RESULT_VALID && guard < STAGE_TIMEOUT) begin
            @(negedge clk);
            guard++;
            if (global_stage == decoder_pkg::STAGE_GROW) begin
                grows++;
                if (grows == 1) busy_left = BUSY_HOLD;
            end
            busy_pe = '0;
            odd_clusters_pe = '0;
            if (busy_left > 0) busy_pe[7] = 1'b1;
            if (busy_left > 0) busy_left--;
            if (grows < 3) odd_clusters_pe[2] = 1'b1;   // odd through two merges
        end
        busy_pe = '0;
        odd_clusters_pe = '0;
        check_result("repeated growth", 3);
        // registered busy stays high one cycle past the last driven cycle
        first_merge = (BUSY_HOLD > MAXIMUM_DELAY) ? BUSY_HOLD + 1 : MAXIMUM_DELAY + 1;
        if (merge_lengths.size() != 3) begin
            report_mismatch("repeated growth", "merge count", 3, merge_lengths.size());
        end else begin
            if (merge_lengths[0] != first_merge)
                report_mismatch("repeated growth", "busy merge length", first_merge,
                                merge_lengths[0]);
            if (merge_lengths[2] != MAXIMUM_DELAY + 1)
                report_mismatch("repeated growth", "last merge length", MAXIMUM_DELAY + 1,
                                merge_lengths[2]);
        end
        wait_for_stage(decoder_pkg::STAGE_IDLE, "repeated growth");
        send_ctrl(decoder_pkg::OP_MOVE_TO_STAGE);
        if (global_stage !== decoder_pkg::STAGE_GROW)
            report_mismatch("move to stage", "stage", decoder_pkg::STAGE_GROW, global_stage);
        wait_for_stage(decoder_pkg::STAGE_IDLE, "move to stage");
    endtask

    task automatic test_output_stream;
        logic [CORR_WIDTH-1:0] words [GRID_U];
        logic [15:0] padded;
        logic [15:0] cycles;
        logic [7:0] expected[$];
        int i;
        int received;
        int guard;
        guard = 0;
        while (output_valid && guard < STAGE_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        output_ready = 1'b0;   // let the words pile up in the FIFO
        busy_pe = '0;
        odd_clusters_pe = '0;
        start_decode();
        wait_for_stage(decoder_pkg::STAGE_RESULT_VALID, "output stream");
        for (i = 0; i < GRID_U; i++) begin
            @(negedge clk);
            words[i] = $urandom;
            correction = words[i];
        end
        cycles = active_cycles + 1;
        expected.push_back(8'd1);
        expected.push_back(cycles[15:8]);
        expected.push_back(cycles[7:0]);
        for (i = 0; i < GRID_U; i++) begin
            padded = words[i];
            expected.push_back(padded[7:0]);
            expected.push_back(padded[15:8]);
        end
        received = 0;
        guard = 0;
        while (received < expected.size() && guard < STAGE_TIMEOUT) begin
            @(negedge clk);
            guard++;
            output_ready = ($urandom % 3) != 0;
            if (output_valid && output_ready) begin
                if (output_data !== expected[received])
                    report_mismatch("output stream", $sformatf("byte %0d", received),
                                    expected[received], output_data);
                received++;
            end
        end
        if (received < expected.size())
            report_problem($sformatf("output stream stopped after %0d bytes", received));
        @(negedge clk);
        output_ready = 1'b1;
        if (output_valid !== 1'b0)
            report_mismatch("output stream", "output_valid after frame", 0, output_valid);
    endtask

    initial begin
        void'($urandom(32'ha3d971fc));
        reset = 1'b1;
        input_data = '0;
        input_valid = 1'b0;
        output_ready = 1'b1;
        ctrl_rx = '0;
        ctrl_rx_valid = 1'b0;
        busy_pe = '0;
        odd_clusters_pe = '0;
        correction = '0;
        clear_monitor();
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        test_reset();
        test_start_message();
        test_measurement_loading();
        test_single_iteration();
        test_repeated_growth();
        test_output_stream();
        @(negedge clk);
        $display("check errors: %0d, assertion failures: %0d", errors,
                 uut.handshake_checks.assertion_failures);
        if (errors == 0 && uut.handshake_checks.assertion_failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/decoder_pkg.sv
source/stage_controller.sv
source/measurement_loader.sv
source/decode_statistics.sv
source/correction_buffer.sv
source/result_serializer.sv
source/decoder_controller.sv
bench/decoder_controller_sva.sv
bench/decoder_controller_tb.sv
